/* assoc_cache.f */
+incdir+include
verilog/cache_types_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/array_access_if.sv
verilog/single_port_lutram.sv
verilog/associative_single_port_array.sv
verilog/cache_controller.sv
verilog/assoc_cache_top.sv
verif/assoc_cache_sva.sv
verif/assoc_cache_tb.sv

/* include/assoc_cache_params.svh */
`ifndef ASSOC_CACHE_PARAMS_SVH
`define ASSOC_CACHE_PARAMS_SVH

// ====================
// Cache geometry
// ====================

`define BYTE_LEN_IN_BITS        8
`define CACHE_NUM_SET           16
`define CACHE_NUM_WAY           4
`define CACHE_WORD_BITS         32
`define CACHE_ADDR_BITS         16

// Valid bit on top, tag in the low bits, zero padding between
`define CACHE_TAG_ENTRY_BITS    16

`endif

/* run_sim.sh */
#!/bin/sh
# Builds the cache testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module assoc_cache_tb \
    -f assoc_cache.f \
    --Mdir obj_dir -o assoc_cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/assoc_cache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi

exit 0

/* verif/assoc_cache_sva.sv */
`timescale 1ns/1ps

module assoc_cache_sva
(
    input  logic                            clk_in,
    input  logic                            reset_in,
    input  logic                            req_valid,
    input  logic                            req_ready,
    input  logic                            resp_valid,
    input  logic                            resp_hit,
    input  logic                            mem_req_valid,
    input  logic                            mem_req_ready,
    input  logic                            mem_req_write,
    input  cache_types_pkg::addr_t          mem_req_addr,
    input  cache_types_pkg::word_t          mem_req_wdata,
    input  cache_types_pkg::byte_en_t       mem_req_byte_en
);

// ====================
// Memory handshake
// ====================

mem_req_held: assert property (@(posedge clk_in) disable iff (reset_in)
    mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_write) &&
        $stable(mem_req_addr) && $stable(mem_req_wdata) && $stable(mem_req_byte_en))
    else $error("Memory request dropped or changed while waiting for ready");

idle_no_mem_req: assert property (@(posedge clk_in) disable iff (reset_in)
    !(req_ready && mem_req_valid))
    else $error("Memory request issued while the cache accepts requests");

// ====================
// Response
// ====================

resp_one_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
    resp_valid |=> !resp_valid)
    else $error("Response strobe longer than one cycle");

// mem_req_write still holds the request kind while the response is out
read_hit_latency: assert property (@(posedge clk_in) disable iff (reset_in)
    resp_valid && resp_hit && !mem_req_write |-> $past(req_valid && req_ready, 3))
    else $error("Read hit response not 2 cycles after acceptance");

endmodule

bind assoc_cache_top assoc_cache_sva u_sva
(
    .clk_in             (clk_in),
    .reset_in           (reset_in),
    .req_valid          (req_valid),
    .req_ready          (req_ready),
    .resp_valid         (resp_valid),
    .resp_hit           (resp_hit),
    .mem_req_valid      (mem_req_valid),
    .mem_req_ready      (mem_req_ready),
    .mem_req_write      (mem_req_write),
    .mem_req_addr       (mem_req_addr),
    .mem_req_wdata      (mem_req_wdata),
    .mem_req_byte_en    (mem_req_byte_en)
);

/* verif/assoc_cache_tb.sv */
`timescale 1ns/1ps
`include "assoc_cache_params.svh"

module assoc_cache_tb;

localparam int          CLK_HALF        = 20;
localparam int          RESET_CYCLES    = 8;
localparam int          MAX_REQUESTS    = 300;
localparam int          MAX_CYCLES      = MAX_REQUESTS * 40;
localparam int          RANDOM_REQUESTS = 240;
localparam int          HIT_FALLS       = 3;   // Strobe 2 cycles after acceptance, seen one fall later
localparam int          MEM_WORDS       = 1 << (`CACHE_ADDR_BITS - 2);
localparam logic [15:0] SEED            = 16'd47380;

localparam int          KIND_DATA       = 0;
localparam int          KIND_HIT        = 1;
localparam int          KIND_PROTOCOL   = 2;

logic                           clk_in = 1'b0;
logic                           reset_in;
logic                           req_valid;
logic                           req_ready;
logic                           req_write;
cache_types_pkg::addr_t         req_addr;
cache_types_pkg::word_t         req_wdata;
cache_types_pkg::byte_en_t      req_byte_en;
logic                           resp_valid;
cache_types_pkg::word_t         resp_rdata;
logic                           resp_hit;
logic                           mem_req_valid;
logic                           mem_req_ready;
logic                           mem_req_write;
cache_types_pkg::addr_t         mem_req_addr;
cache_types_pkg::word_t         mem_req_wdata;
cache_types_pkg::byte_en_t      mem_req_byte_en;
logic                           mem_resp_valid;
cache_types_pkg::word_t         mem_resp_rdata;

int checks;
int data_errors;
int hit_errors;
int protocol_errors;
int cycle_count;
int requests_sent;
int responses_seen;
int mem_requests;

logic [15:0]                    main_lfsr;
logic [15:0]                    mem_lfsr;

// What the current request should put on the memory port
logic                           exp_mem_write;
cache_types_pkg::addr_t         exp_mem_addr;
cache_types_pkg::word_t         exp_mem_wdata;
cache_types_pkg::byte_en_t      exp_mem_mask;

cache_types_pkg::word_t         mem_store [MEM_WORDS];  // Backing memory seen by the DUT
cache_types_pkg::word_t         model_mem [MEM_WORDS];  // Expected memory contents
cache_types_pkg::tag_t          model_tag [`CACHE_NUM_SET][`CACHE_NUM_WAY];
logic                           model_valid [`CACHE_NUM_SET][`CACHE_NUM_WAY];
int                             model_rr [`CACHE_NUM_SET];

assoc_cache_top u_dut (.*);

always #(CLK_HALF) clk_in = ~clk_in;

// ====================
// Helpers
// ====================

// Taps 16, 14, 13, 11
function automatic logic [31:0] rand_bits(inout logic [15:0] state, input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
        fb    = state[15] ^ state[13] ^ state[12] ^ state[10];
        state = {state[14:0], fb};
        value = {value[30:0], fb};
    end
    return value;
endfunction

function automatic cache_types_pkg::word_t fill_word(input int idx);
    logic [13:0] w;
    w = idx[13:0];
    return {w ^ 14'h2A5C, 2'b10, w, 2'b01};
endfunction

function automatic cache_types_pkg::tag_t pool_tag(input int k);
    return cache_types_pkg::tag_t'(k * 67 + 5);
endfunction

function automatic cache_types_pkg::addr_t make_addr(input cache_types_pkg::tag_t tag,
                                                     input cache_types_pkg::set_idx_t set);
    return {tag, set, 2'b00};
endfunction

function automatic cache_types_pkg::word_t merge_bytes(input cache_types_pkg::word_t old_word,
                                                       input cache_types_pkg::word_t new_word,
                                                       input cache_types_pkg::byte_en_t mask);
    cache_types_pkg::word_t result;
    result = old_word;
    for (int b = 0; b < 4; b++)
    begin
        if (mask[b])
            result[b * 8 +: 8] = new_word[b * 8 +: 8];
    end
    return result;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual, input int kind);
    checks++;
    assert (actual === expected)
    else
    begin
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        case (kind)
            KIND_DATA: data_errors++;
            KIND_HIT:  hit_errors++;
            default:   protocol_errors++;
        endcase
    end
endtask

task automatic end_simulation(input bit timed_out);
    $display("Checks %0d, data errors %0d, hit errors %0d, protocol errors %0d",
             checks, data_errors, hit_errors, protocol_errors);
    if (!timed_out && data_errors + hit_errors + protocol_errors == 0)
        $display(">>> PASS");
    else
        $display(">>> FAIL");
    $finish;
endtask

// One request from hand-off to response, checked against the cache model
task automatic run_request(input string name, input logic write,
                           input cache_types_pkg::addr_t addr,
                           input cache_types_pkg::word_t wdata,
                           input cache_types_pkg::byte_en_t mask);
    cache_types_pkg::set_idx_t set;
    cache_types_pkg::tag_t     tag;
    cache_types_pkg::word_t    exp_rdata;
    logic                      exp_hit;
    int                        falls;
    int                        mem_before;
    set       = addr[5:2];
    tag       = addr[15:6];
    exp_hit   = 1'b0;
    for (int w = 0; w < `CACHE_NUM_WAY; w++)
    begin
        if (model_valid[set][w] && model_tag[set][w] == tag)
            exp_hit = 1'b1;
    end
    exp_rdata     = model_mem[addr[15:2]];
    exp_mem_write = write;
    exp_mem_addr  = addr;
    exp_mem_wdata = wdata;
    exp_mem_mask  = mask;
    mem_before    = mem_requests;

    @(negedge clk_in);
    check_value({name, " ready"}, 1, req_ready, KIND_PROTOCOL);
    check_value({name, " response idle"}, 0, resp_valid, KIND_PROTOCOL);
    req_valid     = 1'b1;
    req_write     = write;
    req_addr      = addr;
    req_wdata     = wdata;
    req_byte_en   = mask;
    requests_sent++;
    falls = 0;
    do
    begin
        @(negedge clk_in);
        req_valid = 1'b0;     // Ready was high, so the last rising edge took it
        falls++;
    end while (!resp_valid);

    check_value({name, " hit"}, exp_hit, resp_hit, KIND_HIT);
    if (!write)
        check_value({name, " data"}, exp_rdata, resp_rdata, KIND_DATA);
    if (!write && exp_hit)
        check_value({name, " hit latency"}, HIT_FALLS, falls, KIND_PROTOCOL);
    check_value({name, " memory requests"}, (write || !exp_hit) ? 1 : 0,
                mem_requests - mem_before, KIND_PROTOCOL);

    // Write-through without allocate, read misses fill the round-robin victim
    if (write)
        model_mem[addr[15:2]] = merge_bytes(model_mem[addr[15:2]], wdata, mask);
    else if (!exp_hit)
    begin
        model_tag[set][model_rr[set]]   = tag;
        model_valid[set][model_rr[set]] = 1'b1;
        model_rr[set] = (model_rr[set] + 1) % `CACHE_NUM_WAY;
    end
endtask

// ====================
// Memory model
// ====================

initial
begin
    logic                      in_wait;
    logic                      read_pending;
    int                        stall;
    int                        resp_wait;
    cache_types_pkg::word_t    resp_word;
    cache_types_pkg::addr_t    snap_addr;
    cache_types_pkg::word_t    snap_wdata;
    cache_types_pkg::byte_en_t snap_mask;
    mem_req_ready  = 1'b0;
    mem_resp_valid = 1'b0;
    mem_resp_rdata = '0;
    mem_lfsr       = SEED;
    in_wait        = 1'b0;
    read_pending   = 1'b0;
    stall          = 0;
    resp_wait      = 0;
    for (int i = 0; i < MEM_WORDS; i++)
        mem_store[i] = fill_word(i);
    forever
    begin
        @(negedge clk_in);
        mem_resp_valid = 1'b0;
        if (read_pending)
        begin
            if (resp_wait == 0)
            begin
                mem_resp_valid = 1'b1;
                mem_resp_rdata = resp_word;
                read_pending   = 1'b0;
            end
            else
                resp_wait--;
        end
        if (!mem_req_valid)
            mem_req_ready = 1'b0;
        else
        begin
            if (!in_wait)
            begin
                snap_addr  = mem_req_addr;
                snap_wdata = mem_req_wdata;
                snap_mask  = mem_req_byte_en;
                stall      = rand_bits(mem_lfsr, 2);
                in_wait    = 1'b1;
                mem_requests++;
            end
            else
            begin
                check_value("stalled address", snap_addr, mem_req_addr, KIND_PROTOCOL);
                check_value("stalled data", snap_wdata, mem_req_wdata, KIND_PROTOCOL);
                check_value("stalled mask", snap_mask, mem_req_byte_en, KIND_PROTOCOL);
            end
            if (stall > 0)
            begin
                mem_req_ready = 1'b0;
                stall--;
            end
            else
            begin
                mem_req_ready = 1'b1;   // Valid is held, so the next rising edge accepts
                in_wait       = 1'b0;
                check_value("memory kind", exp_mem_write, mem_req_write, KIND_PROTOCOL);
                check_value("memory address", exp_mem_addr, mem_req_addr, KIND_PROTOCOL);
                if (mem_req_write)
                begin
                    check_value("memory data", exp_mem_wdata, mem_req_wdata, KIND_DATA);
                    check_value("memory mask", exp_mem_mask, mem_req_byte_en, KIND_DATA);
                    mem_store[mem_req_addr[15:2]] = merge_bytes(mem_store[mem_req_addr[15:2]],
                                                                mem_req_wdata, mem_req_byte_en);
                end
                else
                begin
                    resp_word    = mem_store[mem_req_addr[15:2]];
                    resp_wait    = rand_bits(mem_lfsr, 2);
                    read_pending = 1'b1;
                end
            end
        end
    end
end

always @(negedge clk_in)
begin
    if (resp_valid)
        responses_seen++;
end

always @(posedge clk_in)
begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES)
    begin
        $display("Timeout after %0d cycles, a request never got its response", cycle_count);
        end_simulation(1'b1);
    end
end

// ====================
// Stimulus
// ====================

initial
begin
    cache_types_pkg::addr_t    a_addr;
    cache_types_pkg::addr_t    b_addr;
    cache_types_pkg::addr_t    r_addr;
    cache_types_pkg::word_t    r_wdata;
    cache_types_pkg::byte_en_t r_mask;
    logic                      r_write;
    reset_in    = 1'b1;
    req_valid   = 1'b0;
    req_write   = 1'b0;
    req_addr    = '0;
    req_wdata   = '0;
    req_byte_en = '0;
    main_lfsr   = SEED;
    for (int i = 0; i < MEM_WORDS; i++)
        model_mem[i] = fill_word(i);
    for (int s = 0; s < `CACHE_NUM_SET; s++)
    begin
        model_rr[s] = 0;
        for (int w = 0; w < `CACHE_NUM_WAY; w++)
            model_valid[s][w] = 1'b0;
    end

    repeat (RESET_CYCLES) @(negedge clk_in);
    reset_in = 1'b0;
    @(negedge clk_in);
    check_value("ready after reset", 1, req_ready, KIND_PROTOCOL);
    check_value("memory idle after reset", 0, mem_req_valid, KIND_PROTOCOL);
    check_value("response idle after reset", 0, resp_valid, KIND_PROTOCOL);

    // Miss then hit, then writes on both paths
    a_addr = make_addr(pool_tag(0), 4'd3);
    b_addr = make_addr(pool_tag(1), 4'd3);
    run_request("first read", 1'b0, a_addr, '0, '0);
    run_request("repeat read", 1'b0, a_addr, '0, '0);
    run_request("write hit", 1'b1, a_addr, rand_bits(main_lfsr, 32),
                cache_types_pkg::byte_en_t'(rand_bits(main_lfsr, 4)));
    run_request("read after write hit", 1'b0, a_addr, '0, '0);
    run_request("write miss", 1'b1, b_addr, rand_bits(main_lfsr, 32),
                cache_types_pkg::byte_en_t'(rand_bits(main_lfsr, 4)));
    run_request("read after write miss", 1'b0, b_addr, '0, '0);

    // Five tags in one set, the fifth pushes out the first
    for (int k = 0; k < 5; k++)
        run_request($sformatf("eviction tag %0d", k), 1'b0, make_addr(pool_tag(k), 4'd9), '0, '0);
    run_request("evicted tag 0", 1'b0, make_addr(pool_tag(0), 4'd9), '0, '0);
    run_request("kept tag 2", 1'b0, make_addr(pool_tag(2), 4'd9), '0, '0);

    for (int i = 0; i < RANDOM_REQUESTS; i++)
    begin
        r_write = (rand_bits(main_lfsr, 2) == 0);
        r_addr  = make_addr(pool_tag(rand_bits(main_lfsr, 3)),
                            cache_types_pkg::set_idx_t'(rand_bits(main_lfsr, 4)));
        r_wdata = rand_bits(main_lfsr, 32);
        r_mask  = cache_types_pkg::byte_en_t'(rand_bits(main_lfsr, 4));
        run_request($sformatf("random %0d", i), r_write, r_addr, r_wdata, r_mask);
    end

    repeat (4) @(negedge clk_in);
    check_value("responses per request", requests_sent, responses_seen, KIND_PROTOCOL);
    end_simulation(1'b0);
end

endmodule

/* verilog/array_access_if.sv */
`timescale 1ns/1ps
`include "assoc_cache_params.svh"

interface array_access_if
#(
    parameter ENTRY_BITS = 32,
    parameter NUM_SET    = 16,
    parameter NUM_WAY    = 4
);

logic                                           access_en;
logic [ENTRY_BITS / `BYTE_LEN_IN_BITS - 1 : 0]  write_en;     // Byte mask, zero for a read
logic [$clog2(NUM_SET) - 1 : 0]                 set_addr;
logic [NUM_WAY - 1 : 0]                         way_select;
logic [ENTRY_BITS - 1 : 0]                      write_entry;
logic [ENTRY_BITS - 1 : 0]                      read_entry;   // Selected way, one cycle late

modport ctrl
(
    output access_en, write_en, set_addr, way_select, write_entry,
    input  read_entry
);

modport array
(
    input  access_en, write_en, set_addr, way_select, write_entry,
    output read_entry
);

endinterface

/* verilog/assoc_cache_top.sv */
`timescale 1ns/1ps
`include "assoc_cache_params.svh"

module assoc_cache_top
(
    input  logic                            clk_in,
    input  logic                            reset_in,

    input  logic                            req_valid,
    output logic                            req_ready,
    input  logic                            req_write,
    input  cache_types_pkg::addr_t          req_addr,
    input  cache_types_pkg::word_t          req_wdata,
    input  cache_types_pkg::byte_en_t       req_byte_en,

    output logic                            resp_valid,
    output cache_types_pkg::word_t          resp_rdata,
    output logic                            resp_hit,

    output logic                            mem_req_valid,
    input  logic                            mem_req_ready,
    output logic                            mem_req_write,
    output cache_types_pkg::addr_t          mem_req_addr,
    output cache_types_pkg::word_t          mem_req_wdata,
    output cache_types_pkg::byte_en_t       mem_req_byte_en,
    input  logic                            mem_resp_valid,
    input  cache_types_pkg::word_t          mem_resp_rdata
);

cache_types_pkg::tag_entry_t [`CACHE_NUM_WAY - 1 : 0] tag_set;

array_access_if #(.ENTRY_BITS(`CACHE_TAG_ENTRY_BITS), .NUM_SET(`CACHE_NUM_SET),
                  .NUM_WAY(`CACHE_NUM_WAY)) tag_bus ();
array_access_if #(.ENTRY_BITS(`CACHE_WORD_BITS), .NUM_SET(`CACHE_NUM_SET),
                  .NUM_WAY(`CACHE_NUM_WAY)) data_bus ();

cache_controller ctrl
(
    .reset_in           (reset_in),
    .clk_in             (clk_in),
    .req_valid          (req_valid),
    .req_ready          (req_ready),
    .req_write          (req_write),
    .req_addr           (req_addr),
    .req_wdata          (req_wdata),
    .req_byte_en        (req_byte_en),
    .resp_valid         (resp_valid),
    .resp_rdata         (resp_rdata),
    .resp_hit           (resp_hit),
    .mem_req_valid      (mem_req_valid),
    .mem_req_ready      (mem_req_ready),
    .mem_req_write      (mem_req_write),
    .mem_req_addr       (mem_req_addr),
    .mem_req_wdata      (mem_req_wdata),
    .mem_req_byte_en    (mem_req_byte_en),
    .mem_resp_valid     (mem_resp_valid),
    .mem_resp_rdata     (mem_resp_rdata),
    .tag_bus            (tag_bus),
    .data_bus           (data_bus),
    .tag_set            (tag_set)
);

// All ways' tags go straight to the compare
associative_single_port_array
#(
    .SINGLE_ENTRY_SIZE_IN_BITS  (`CACHE_TAG_ENTRY_BITS),
    .NUM_SET                    (`CACHE_NUM_SET),
    .NUM_WAY                    (`CACHE_NUM_WAY)
)
tag_array
(
    .reset_in                   (reset_in),
    .clk_in                     (clk_in),
    .bus                        (tag_bus),
    .read_set                   (tag_set)
);

// Data leaves only through the muxed bus word
associative_single_port_array
#(
    .SINGLE_ENTRY_SIZE_IN_BITS  (`CACHE_WORD_BITS),
    .NUM_SET                    (`CACHE_NUM_SET),
    .NUM_WAY                    (`CACHE_NUM_WAY)
)
data_array
(
    .reset_in                   (reset_in),
    .clk_in                     (clk_in),
    .bus                        (data_bus),
    .read_set                   ()
);

endmodule

/* verilog/associative_single_port_array.sv */
`timescale 1ns/1ps
`include "assoc_cache_params.svh"

module associative_single_port_array
#(
    parameter SINGLE_ENTRY_SIZE_IN_BITS = 32,
    parameter NUM_SET                   = 16,
    parameter NUM_WAY                   = 4
)
(
    input  logic                                                reset_in,
    input  logic                                                clk_in,

    array_access_if.array                                       bus,

    output logic [SINGLE_ENTRY_SIZE_IN_BITS * NUM_WAY - 1 : 0]  read_set
);

localparam int WRITE_MASK_LEN = SINGLE_ENTRY_SIZE_IN_BITS / `BYTE_LEN_IN_BITS;

// ====================
// Storage, one LUT-RAM per way
// ====================

generate
    genvar gen;

    for (gen = 0; gen < NUM_WAY; gen = gen + 1)
    begin : way
        single_port_lutram
        #(
            .SINGLE_ENTRY_SIZE_IN_BITS  (SINGLE_ENTRY_SIZE_IN_BITS),
            .NUM_SET                    (NUM_SET)
        )
        entry_way
        (
            .reset_in                   (reset_in),
            .clk_in                     (clk_in),

            .access_en_in               (bus.access_en & bus.way_select[gen]),
            .write_en_in                (bus.write_en & {WRITE_MASK_LEN{bus.way_select[gen]}}),

            .access_set_addr_in         (bus.set_addr),

            .write_entry_in             (bus.write_entry),
            .read_entry_out             (read_set[gen * SINGLE_ENTRY_SIZE_IN_BITS +:
                                                  SINGLE_ENTRY_SIZE_IN_BITS])
        );
    end
endgenerate

// ====================
// Way select and output mux
// ====================

logic [NUM_WAY - 1 : 0]                   way_select_stage;
logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0] selected_entry;

// Lines up with the registered read data of the ways
always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        way_select_stage <= '0;
    end
    else
    begin
        way_select_stage <= bus.way_select;
    end
end

// One-hot select; several bits set would OR the ways together
always_comb
begin
    selected_entry = '0;
    for (int w = 0; w < NUM_WAY; w++)
    begin
        if (way_select_stage[w])
        begin
            selected_entry = selected_entry |
                             read_set[w * SINGLE_ENTRY_SIZE_IN_BITS +: SINGLE_ENTRY_SIZE_IN_BITS];
        end
    end
end

assign bus.read_entry = selected_entry;

endmodule

/* verilog/cache_controller.sv */
`timescale 1ns/1ps
`include "assoc_cache_params.svh"

module cache_controller
(
    input  logic                                            reset_in,
    input  logic                                            clk_in,

    input  logic                                            req_valid,
    output logic                                            req_ready,
    input  logic                                            req_write,
    input  cache_types_pkg::addr_t                          req_addr,
    input  cache_types_pkg::word_t                          req_wdata,
    input  cache_types_pkg::byte_en_t                       req_byte_en,

    output logic                                            resp_valid,
    output cache_types_pkg::word_t                          resp_rdata,
    output logic                                            resp_hit,

    output logic                                            mem_req_valid,
    input  logic                                            mem_req_ready,
    output logic                                            mem_req_write,
    output cache_types_pkg::addr_t                          mem_req_addr,
    output cache_types_pkg::word_t                          mem_req_wdata,
    output cache_types_pkg::byte_en_t                       mem_req_byte_en,
    input  logic                                            mem_resp_valid,
    input  cache_types_pkg::word_t                          mem_resp_rdata,

    array_access_if.ctrl                                    tag_bus,
    array_access_if.ctrl                                    data_bus,
    input  cache_types_pkg::tag_entry_t [`CACHE_NUM_WAY - 1 : 0] tag_set
);

localparam int OFFSET_BITS  = $clog2(`CACHE_WORD_BITS / `BYTE_LEN_IN_BITS);
localparam int SET_BITS     = $bits(cache_types_pkg::set_idx_t);
localparam int TAG_BITS     = $bits(cache_types_pkg::tag_t);
localparam int TAG_PAD_BITS = `CACHE_TAG_ENTRY_BITS - 1 - TAG_BITS;
localparam int PTR_BITS     = $clog2(`CACHE_NUM_WAY);

cache_ctrl_pkg::ctrl_state_t    state;
cache_ctrl_pkg::ctrl_state_t    state_next;

// Request held for the whole transaction
cache_types_pkg::addr_t         addr_q;
logic                           write_q;
cache_types_pkg::word_t         wdata_q;
cache_types_pkg::byte_en_t      byte_en_q;

logic                           hit_q;
cache_types_pkg::way_mask_t     hit_way_q;
logic                           read_issued_q;
cache_types_pkg::word_t         rdata_q;
logic [PTR_BITS - 1 : 0]        rr_ptr [`CACHE_NUM_SET];

cache_types_pkg::set_idx_t      req_set;
cache_types_pkg::tag_t          req_tag;
cache_types_pkg::way_mask_t     hit_way;
cache_types_pkg::way_mask_t     victim_way;
cache_types_pkg::tag_entry_t    new_tag_entry;

assign req_set       = addr_q[OFFSET_BITS +: SET_BITS];
assign req_tag       = addr_q[`CACHE_ADDR_BITS - 1 -: TAG_BITS];
assign victim_way    = cache_types_pkg::way_mask_t'(1) << rr_ptr[req_set];
assign new_tag_entry = {1'b1, {TAG_PAD_BITS{1'b0}}, req_tag};

always_comb
begin
    for (int w = 0; w < `CACHE_NUM_WAY; w++)
    begin
        hit_way[w] = tag_set[w][`CACHE_TAG_ENTRY_BITS - 1] &&
                     (tag_set[w][TAG_BITS - 1 : 0] == req_tag);
    end
end

// ====================
// FSM
// ====================

always_comb
begin
    state_next = state;
    case (state)
        cache_ctrl_pkg::IDLE:      if (req_valid) state_next = cache_ctrl_pkg::LOOKUP;
        cache_ctrl_pkg::LOOKUP:    state_next = cache_ctrl_pkg::COMPARE;
        cache_ctrl_pkg::COMPARE:
        begin
            if (write_q)
                state_next = cache_ctrl_pkg::MEM_WRITE;
            else if (|hit_way)
                state_next = cache_ctrl_pkg::RESPOND;
            else
                state_next = cache_ctrl_pkg::MEM_READ;
        end
        cache_ctrl_pkg::MEM_READ:  if (read_issued_q && mem_resp_valid) state_next = cache_ctrl_pkg::REFILL;
        cache_ctrl_pkg::REFILL:    state_next = cache_ctrl_pkg::RESPOND;
        cache_ctrl_pkg::MEM_WRITE: if (mem_req_ready) state_next = cache_ctrl_pkg::RESPOND;
        default:                   state_next = cache_ctrl_pkg::IDLE;
    endcase
end

always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        state         <= cache_ctrl_pkg::IDLE;
        hit_q         <= 1'b0;
        hit_way_q     <= '0;
        read_issued_q <= 1'b0;
        for (int s = 0; s < `CACHE_NUM_SET; s++)
        begin
            rr_ptr[s] <= '0;
        end
    end
    else
    begin
        state <= state_next;
        if (state == cache_ctrl_pkg::COMPARE)
        begin
            hit_q     <= |hit_way;
            hit_way_q <= hit_way;
        end
        // Memory answers a read no earlier than the cycle after acceptance
        if (state == cache_ctrl_pkg::MEM_READ && mem_req_ready)
            read_issued_q <= 1'b1;
        else if (state != cache_ctrl_pkg::MEM_READ)
            read_issued_q <= 1'b0;
        if (state == cache_ctrl_pkg::REFILL)
            rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;   // Victim choice moves on every refill
    end
end

always_ff @(posedge clk_in)
begin
    if (req_valid && req_ready)
    begin
        addr_q    <= req_addr;
        write_q   <= req_write;
        wdata_q   <= req_wdata;
        byte_en_q <= req_byte_en;
    end
    if (state == cache_ctrl_pkg::MEM_READ && read_issued_q && mem_resp_valid)
        rdata_q <= mem_resp_rdata;
end

// ====================
// Outputs
// ====================

assign req_ready  = (state == cache_ctrl_pkg::IDLE);
assign resp_valid = (state == cache_ctrl_pkg::RESPOND);
assign resp_hit   = hit_q;
// Hit word comes through the array mux, a refilled word from memory; writes return no data
assign resp_rdata = (hit_q && !write_q) ? data_bus.read_entry : rdata_q;

assign mem_req_valid   = (state == cache_ctrl_pkg::MEM_READ && !read_issued_q) ||
                         (state == cache_ctrl_pkg::MEM_WRITE);
assign mem_req_write   = write_q;
assign mem_req_addr    = addr_q;
assign mem_req_wdata   = wdata_q;
assign mem_req_byte_en = byte_en_q;

always_comb
begin
    tag_bus.access_en    = 1'b0;
    tag_bus.write_en     = '0;
    tag_bus.set_addr     = req_set;
    tag_bus.way_select   = '0;
    tag_bus.write_entry  = new_tag_entry;
    data_bus.access_en   = 1'b0;
    data_bus.write_en    = '0;
    data_bus.set_addr    = req_set;
    data_bus.way_select  = '0;
    data_bus.write_entry = wdata_q;
    case (state)
        cache_ctrl_pkg::LOOKUP:
        begin
            tag_bus.access_en   = 1'b1;
            tag_bus.way_select  = '1;
            data_bus.access_en  = 1'b1;
            data_bus.way_select = '1;
        end
        cache_ctrl_pkg::COMPARE:   data_bus.way_select = hit_way;   // Picked up by the registered mux
        cache_ctrl_pkg::REFILL:
        begin
            tag_bus.access_en    = 1'b1;
            tag_bus.write_en     = '1;
            tag_bus.way_select   = victim_way;
            data_bus.access_en   = 1'b1;
            data_bus.write_en    = '1;
            data_bus.way_select  = victim_way;
            data_bus.write_entry = rdata_q;
        end
        cache_ctrl_pkg::MEM_WRITE:
        begin
            data_bus.access_en  = hit_q && mem_req_ready;
            data_bus.write_en   = byte_en_q;
            data_bus.way_select = hit_way_q;
        end
        default:;
    endcase
end

endmodule

/* verilog/cache_ctrl_pkg.sv */
package cache_ctrl_pkg;

// ====================
// Controller FSM
// ====================

typedef enum logic [2:0]
{
    IDLE,           // Waiting for a request, req_ready high
    LOOKUP,         // All ways of the set are read
    COMPARE,        // Tag match on the registered tag entries
    MEM_READ,       // Read miss, request and then wait for the memory word
    REFILL,         // Victim way takes the new tag and word
    MEM_WRITE,      // Write-through to memory, hit way updated on acceptance
    RESPOND         // One-cycle response strobe
} ctrl_state_t;

endpackage

/* verilog/cache_types_pkg.sv */
`include "assoc_cache_params.svh"

package cache_types_pkg;

// Byte address split as tag | set index | byte offset
typedef logic [`CACHE_ADDR_BITS - 1 : 0]                            addr_t;
typedef logic [`CACHE_ADDR_BITS - $clog2(`CACHE_NUM_SET)
               - $clog2(`CACHE_WORD_BITS / `BYTE_LEN_IN_BITS) - 1 : 0] tag_t;
typedef logic [$clog2(`CACHE_NUM_SET) - 1 : 0]                      set_idx_t;

// Payload
typedef logic [`CACHE_WORD_BITS - 1 : 0]                            word_t;
typedef logic [`CACHE_WORD_BITS / `BYTE_LEN_IN_BITS - 1 : 0]        byte_en_t;

// One bit per way, at most one set
typedef logic [`CACHE_NUM_WAY - 1 : 0]                              way_mask_t;

// What the tag array stores per way
typedef logic [`CACHE_TAG_ENTRY_BITS - 1 : 0]                       tag_entry_t;

endpackage

/* verilog/single_port_lutram.sv */
`timescale 1ns/1ps
`include "assoc_cache_params.svh"

module single_port_lutram
#(
    parameter SINGLE_ENTRY_SIZE_IN_BITS = 32,
    parameter NUM_SET                   = 16
)
(
    input  logic                                                        reset_in,
    input  logic                                                        clk_in,

    input  logic                                                        access_en_in,
    input  logic [SINGLE_ENTRY_SIZE_IN_BITS / `BYTE_LEN_IN_BITS - 1 : 0] write_en_in,
    input  logic [$clog2(NUM_SET) - 1 : 0]                              access_set_addr_in,

    input  logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0]                    write_entry_in,
    output logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0]                    read_entry_out
);

localparam int MASK_LEN = SINGLE_ENTRY_SIZE_IN_BITS / `BYTE_LEN_IN_BITS;
localparam int BYTE     = `BYTE_LEN_IN_BITS;

logic [SINGLE_ENTRY_SIZE_IN_BITS - 1 : 0] entries [NUM_SET];

// Cleared on reset so that stored valid bits start at zero
always_ff @(posedge clk_in or posedge reset_in)
begin
    if (reset_in)
    begin
        for (int s = 0; s < NUM_SET; s++)
        begin
            entries[s] <= '0;
        end
    end
    else if (access_en_in)
    begin
        for (int b = 0; b < MASK_LEN; b++)
        begin
            if (write_en_in[b])
            begin
                entries[access_set_addr_in][b * BYTE +: BYTE] <= write_entry_in[b * BYTE +: BYTE];
            end
        end
    end
end

// Read returns the word as it was before a write in the same cycle
always_ff @(posedge clk_in)
begin
    if (access_en_in)
    begin
        read_entry_out <= entries[access_set_addr_in];
    end
end

endmodule
